// ==== rtl/strm_settings.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streamer settings
// Word, address and job field widths plus the depth of every channel FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef STRM_SETTINGS_SVH
`define STRM_SETTINGS_SVH

// Data word width in bits
`define STRM_DW 32

// Word address width
`define STRM_AW 16

// Width of the length and stride job fields
`define STRM_LW 8

// Entries per load and store FIFO, power of two
`define STRM_FIFO_DEPTH 4

`endif

// ==== rtl/strm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streamer package
// Job, flag, stream beat and memory port types shared by all channels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "strm_settings.svh"

package strm_pkg;

  // Channel index into start, done, busy and arbiter vectors
  localparam int unsigned STRM_CH_X = 0;
  localparam int unsigned STRM_CH_W = 1;
  localparam int unsigned STRM_CH_Y = 2;
  localparam int unsigned STRM_CH_Z = 3;

  // One strided run of words
  typedef struct packed {
    logic [`STRM_AW-1:0] base;
    // Step between words
    logic [`STRM_LW-1:0] stride;
    // Beats to move, zero means none
    logic [`STRM_LW-1:0] length;
  } strm_job_t;

  // Jobs for all channels plus one start pulse per channel
  typedef struct packed {
    strm_job_t  x;
    strm_job_t  w;
    strm_job_t  y;
    strm_job_t  z;
    logic [3:0] start;
  } strm_cfg_t;

  // Per channel status, same bit order as start
  typedef struct packed {
    logic [3:0] done;
    logic [3:0] busy;
  } strm_flags_t;

  // Stream payload
  typedef struct packed {
    logic [`STRM_DW-1:0] data;
    logic                last;
  } strm_beat_t;

  // Memory request, held until granted
  typedef struct packed {
    logic                req;
    logic                we;
    logic [`STRM_AW-1:0] addr;
    logic [`STRM_DW-1:0] wdata;
  } strm_mem_req_t;

  // Read data, one cycle after the grant
  typedef struct packed {
    logic                rvalid;
    logic [`STRM_DW-1:0] rdata;
  } strm_mem_rsp_t;

  // Store FIFO entry
  typedef struct packed {
    logic [`STRM_AW-1:0] addr;
    logic [`STRM_DW-1:0] data;
  } strm_wr_t;

endpackage : strm_pkg

// ==== rtl/strm_addr_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strided address generator
// Walks base, base + stride, ... and counts the beats of one job down
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "strm_settings.svh"

module strm_addr_gen
  import strm_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_i,
  input  logic                load_i,
  input  strm_job_t           job_i,
  input  logic                step_i,
  output logic [`STRM_AW-1:0] addr_o,
  output logic                last_o,
  output logic                active_o
);

  localparam logic [`STRM_LW-1:0] ONE_BEAT = {{(`STRM_LW-1){1'b0}}, 1'b1};

  logic [`STRM_AW-1:0] addr_q;
  logic [`STRM_LW-1:0] stride_q;
  logic [`STRM_LW-1:0] left_q;
  logic                active_q;
  logic                do_step;

  // Steps outside a job are ignored
  assign do_step = step_i && active_q;

  // Beat counter and activity
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      left_q   <= '0;
      active_q <= 1'b0;
    end else if (clear_i) begin
      left_q   <= '0;
      active_q <= 1'b0;
    end else if (load_i) begin
      left_q   <= job_i.length;
      active_q <= (job_i.length != '0);
    end else if (do_step) begin
      left_q <= left_q - ONE_BEAT;
      // Drop out on the step that takes the final address
      if (left_q == ONE_BEAT) begin
        active_q <= 1'b0;
      end
    end
  end

  // Address walk, stride zero extended to the address width
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      addr_q   <= job_i.base;
      stride_q <= job_i.stride;
    end else if (do_step) begin
      addr_q <= addr_q + {{(`STRM_AW-`STRM_LW){1'b0}}, stride_q};
    end
  end

  assign addr_o   = addr_q;
  assign last_o   = active_q && (left_q == ONE_BEAT);
  assign active_o = active_q;

endmodule : strm_addr_gen

// ==== rtl/strm_fifo.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Show-ahead FIFO
// Circular buffer of any payload type, head word visible while not empty
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "strm_settings.svh"

module strm_fifo #(
  parameter type T = logic
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       clear_i,
  input  logic       push_i,
  input  T           data_i,
  output logic       full_o,
  input  logic       pop_i,
  output T           data_o,
  output logic       empty_o,
  output logic [2:0] count_o
);

  localparam int unsigned DEPTH = `STRM_FIFO_DEPTH;
  localparam int unsigned PW    = $clog2(DEPTH);

  T              mem_q [DEPTH];
  logic [PW-1:0] wr_ptr_q;
  logic [PW-1:0] rd_ptr_q;
  logic [2:0]    count_q;
  logic          do_push;
  logic          do_pop;

  assign full_o  = (count_q == 3'(DEPTH));
  assign empty_o = (count_q == 3'd0);

  // Push into a full buffer or pop from an empty one is dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap naturally on a power-of-two depth
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 3'd1;
        2'b01:   count_q <= count_q - 3'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign count_o = count_q;

endmodule : strm_fifo

// ==== rtl/strm_source.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load channel
// Reads a strided run of words and replays them as a valid/ready stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "strm_settings.svh"

module strm_source
  import strm_pkg::*;
(
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                clear_i,
  input  logic                start_i,
  input  strm_job_t           job_i,
  output strm_mem_req_t       req_o,
  input  logic                gnt_i,
  input  logic                rvalid_i,
  input  logic [`STRM_DW-1:0] rdata_i,
  output strm_beat_t          beat_o,
  output logic                valid_o,
  input  logic                ready_i,
  output logic                done_o,
  output logic                busy_o
);

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN,
    DONE
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic                accept_start;
  logic [`STRM_AW-1:0] ag_addr;
  logic                ag_last;
  logic                ag_active;
  logic                ag_step;
  logic [2:0]          out_cnt_q;
  logic [2:0]          fifo_cnt;
  logic [3:0]          credit_use;
  logic                can_issue;
  logic                rd_last_q;
  strm_beat_t          rsp_beat;
  logic                fifo_push;
  logic                fifo_pop;
  logic                fifo_empty;

  // Busy channels ignore start
  assign accept_start = start_i && (state_q == IDLE || state_q == DONE);
  assign busy_o       = (state_q == ISSUE) || (state_q == DRAIN);
  assign done_o       = (state_q == DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        // Empty job finishes at once
        if (accept_start) begin
          state_d = (job_i.length == '0) ? DONE : ISSUE;
        end
      end
      ISSUE: begin
        if (ag_step && ag_last) begin
          state_d = DRAIN;
        end
      end
      DRAIN: begin
        // Final beat leaves the stream
        if (fifo_pop && beat_o.last) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  strm_addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (clear_i),
    .load_i   (accept_start),
    .job_i    (job_i),
    .step_i   (ag_step),
    .addr_o   (ag_addr),
    .last_o   (ag_last),
    .active_o (ag_active)
  );

  // Credit check, buffered beats plus reads in flight never exceed the FIFO
  assign credit_use = {1'b0, fifo_cnt} + {1'b0, out_cnt_q};
  assign can_issue  = (credit_use < 4'(`STRM_FIFO_DEPTH));

  // Read request, credit only grows while it waits for a grant
  assign req_o.req   = (state_q == ISSUE) && ag_active && can_issue;
  assign req_o.we    = 1'b0;
  assign req_o.addr  = ag_addr;
  assign req_o.wdata = '0;
  assign ag_step     = req_o.req && gnt_i;

  // Responses after a clear are not taken
  assign fifo_push     = rvalid_i && busy_o;
  assign rsp_beat.data = rdata_i;
  assign rsp_beat.last = rd_last_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      out_cnt_q <= '0;
      rd_last_q <= 1'b0;
    end else if (clear_i) begin
      state_q   <= IDLE;
      out_cnt_q <= '0;
      rd_last_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // Response follows its grant by one cycle, so the tag does too
      rd_last_q <= ag_step && ag_last;
      case ({ag_step, fifo_push})
        2'b10:   out_cnt_q <= out_cnt_q + 3'd1;
        2'b01:   out_cnt_q <= out_cnt_q - 3'd1;
        default: out_cnt_q <= out_cnt_q;
      endcase
    end
  end

  strm_fifo #(
    .T (strm_beat_t)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (clear_i),
    .push_i  (fifo_push),
    .data_i  (rsp_beat),
    .full_o  (),
    .pop_i   (fifo_pop),
    .data_o  (beat_o),
    .empty_o (fifo_empty),
    .count_o (fifo_cnt)
  );

  // Stream side
  assign valid_o  = !fifo_empty;
  assign fifo_pop = valid_o && ready_i;

endmodule : strm_source

// ==== rtl/strm_sink.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store channel
// Tags incoming stream beats with strided addresses and writes them out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "strm_settings.svh"

module strm_sink
  import strm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  logic          start_i,
  input  strm_job_t     job_i,
  input  strm_beat_t    beat_i,
  input  logic          valid_i,
  output logic          ready_o,
  output strm_mem_req_t req_o,
  input  logic          gnt_i,
  output logic          done_o,
  output logic          busy_o
);

  localparam logic [`STRM_LW-1:0] ONE_BEAT = {{(`STRM_LW-1){1'b0}}, 1'b1};

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e              state_q;
  state_e              state_d;
  logic                accept_start;
  logic [`STRM_AW-1:0] ag_addr;
  logic                ag_active;
  logic                ag_step;
  logic [`STRM_LW-1:0] wr_left_q;
  strm_wr_t            fifo_in;
  strm_wr_t            fifo_out;
  logic                fifo_full;
  logic                fifo_empty;
  logic                fifo_pop;
  logic                wr_done;

  assign accept_start = start_i && (state_q != RUN);
  assign busy_o       = (state_q == RUN);
  assign done_o       = (state_q == DONE);

  // Ends on the write count, the stream last bit is not looked at
  assign wr_done = fifo_pop && (wr_left_q == ONE_BEAT);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, DONE: begin
        if (accept_start) begin
          state_d = (job_i.length == '0) ? DONE : RUN;
        end
      end
      RUN: begin
        if (wr_done) begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      wr_left_q <= '0;
    end else if (clear_i) begin
      state_q   <= IDLE;
      wr_left_q <= '0;
    end else begin
      state_q <= state_d;
      if (accept_start) begin
        wr_left_q <= job_i.length;
      end else if (fifo_pop) begin
        wr_left_q <= wr_left_q - ONE_BEAT;
      end
    end
  end

  strm_addr_gen u_addr_gen (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .clear_i  (clear_i),
    .load_i   (accept_start),
    .job_i    (job_i),
    .step_i   (ag_step),
    .addr_o   (ag_addr),
    .last_o   (),
    .active_o (ag_active)
  );

  // Accept only the job's beats and only with room to buffer them
  assign ready_o      = (state_q == RUN) && ag_active && !fifo_full;
  assign ag_step      = valid_i && ready_o;
  assign fifo_in.addr = ag_addr;
  assign fifo_in.data = beat_i.data;

  strm_fifo #(
    .T (strm_wr_t)
  ) u_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (clear_i),
    .push_i  (ag_step),
    .data_i  (fifo_in),
    .full_o  (fifo_full),
    .pop_i   (fifo_pop),
    .data_o  (fifo_out),
    .empty_o (fifo_empty),
    .count_o ()
  );

  // FIFO head is the pending write and stays put until granted
  assign req_o.req   = !fifo_empty;
  assign req_o.we    = 1'b1;
  assign req_o.addr  = fifo_out.addr;
  assign req_o.wdata = fifo_out.data;
  assign fifo_pop    = req_o.req && gnt_i;

endmodule : strm_sink

// ==== rtl/strm_mem_arb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory port arbiter
// Round-robin over four channels with read responses routed by channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module strm_mem_arb
  import strm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  strm_mem_req_t ch_req_i [4],
  output logic [3:0]    ch_gnt_o,
  output logic [3:0]    ch_rvalid_o,
  output strm_mem_req_t mem_req_o,
  input  logic          mem_gnt_i,
  input  strm_mem_rsp_t mem_rsp_i
);

  // Pointer starts on Z so X has first pick
  localparam logic [1:0] PTR_INIT = 2'(STRM_CH_Z);

  logic [1:0] last_q;
  logic [1:0] idx;
  logic [1:0] sel;
  logic       any;
  logic       grant;
  logic [1:0] rd_ch_q;
  logic       rd_pend_q;

  // Scan from the channel after the last winner, last winner comes last
  always_comb begin
    sel = last_q;
    any = 1'b0;
    idx = last_q;
    for (int i = 1; i <= 4; i++) begin
      idx = last_q + 2'(i);
      if (!any && ch_req_i[idx].req) begin
        sel = idx;
        any = 1'b1;
      end
    end
  end

  // Winner goes straight to memory, no added latency
  assign mem_req_o = any ? ch_req_i[sel] : '0;
  assign grant     = any && mem_gnt_i;
  assign ch_gnt_o  = grant ? (4'b0001 << sel) : 4'b0000;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      last_q    <= PTR_INIT;
      rd_ch_q   <= '0;
      rd_pend_q <= 1'b0;
    end else if (clear_i) begin
      last_q    <= PTR_INIT;
      rd_ch_q   <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      // Read data comes back the cycle after its grant
      rd_pend_q <= grant && !ch_req_i[sel].we;
      if (grant) begin
        last_q  <= sel;
        rd_ch_q <= sel;
      end
    end
  end

  // Steer rvalid to the channel whose read was granted last cycle
  assign ch_rvalid_o = (rd_pend_q && mem_rsp_i.rvalid) ? (4'b0001 << rd_ch_q) : 4'b0000;

endmodule : strm_mem_arb

// ==== rtl/strm_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory streamer top
// X, W and Y load streams plus the Z store stream on one memory port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module strm_top
  import strm_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  strm_cfg_t     cfg_i,
  output strm_flags_t   flags_o,
  output strm_beat_t    x_beat_o,
  output logic          x_valid_o,
  input  logic          x_ready_i,
  output strm_beat_t    w_beat_o,
  output logic          w_valid_o,
  input  logic          w_ready_i,
  output strm_beat_t    y_beat_o,
  output logic          y_valid_o,
  input  logic          y_ready_i,
  input  strm_beat_t    z_beat_i,
  input  logic          z_valid_i,
  output logic          z_ready_o,
  output strm_mem_req_t mem_req_o,
  input  logic          mem_gnt_i,
  input  strm_mem_rsp_t mem_rsp_i
);

  // Load channels indexed X, W, Y
  strm_job_t     src_job   [3];
  strm_beat_t    src_beat  [3];
  logic          src_valid [3];
  logic          src_ready [3];
  strm_mem_req_t ch_req    [4];
  logic [3:0]    ch_gnt;
  logic [3:0]    ch_rvalid;
  wire  [3:0]    ch_done;
  wire  [3:0]    ch_busy;

  assign src_job[STRM_CH_X]   = cfg_i.x;
  assign src_job[STRM_CH_W]   = cfg_i.w;
  assign src_job[STRM_CH_Y]   = cfg_i.y;
  assign src_ready[STRM_CH_X] = x_ready_i;
  assign src_ready[STRM_CH_W] = w_ready_i;
  assign src_ready[STRM_CH_Y] = y_ready_i;

  // One load channel per source stream, all share the read data bus
  for (genvar i = 0; i < 3; i++) begin : gen_src
    strm_source u_source (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .clear_i  (clear_i),
      .start_i  (cfg_i.start[i]),
      .job_i    (src_job[i]),
      .req_o    (ch_req[i]),
      .gnt_i    (ch_gnt[i]),
      .rvalid_i (ch_rvalid[i]),
      .rdata_i  (mem_rsp_i.rdata),
      .beat_o   (src_beat[i]),
      .valid_o  (src_valid[i]),
      .ready_i  (src_ready[i]),
      .done_o   (ch_done[i]),
      .busy_o   (ch_busy[i])
    );
  end

  assign x_beat_o  = src_beat[STRM_CH_X];
  assign x_valid_o = src_valid[STRM_CH_X];
  assign w_beat_o  = src_beat[STRM_CH_W];
  assign w_valid_o = src_valid[STRM_CH_W];
  assign y_beat_o  = src_beat[STRM_CH_Y];
  assign y_valid_o = src_valid[STRM_CH_Y];

  // Store channel, writes only so its rvalid bit stays unused
  strm_sink u_sink (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clear_i (clear_i),
    .start_i (cfg_i.start[STRM_CH_Z]),
    .job_i   (cfg_i.z),
    .beat_i  (z_beat_i),
    .valid_i (z_valid_i),
    .ready_o (z_ready_o),
    .req_o   (ch_req[STRM_CH_Z]),
    .gnt_i   (ch_gnt[STRM_CH_Z]),
    .done_o  (ch_done[STRM_CH_Z]),
    .busy_o  (ch_busy[STRM_CH_Z])
  );

  strm_mem_arb u_mem_arb (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clear_i     (clear_i),
    .ch_req_i    (ch_req),
    .ch_gnt_o    (ch_gnt),
    .ch_rvalid_o (ch_rvalid),
    .mem_req_o   (mem_req_o),
    .mem_gnt_i   (mem_gnt_i),
    .mem_rsp_i   (mem_rsp_i)
  );

  assign flags_o.done = ch_done;
  assign flags_o.busy = ch_busy;

endmodule : strm_top

// ==== tb/strm_chk.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Streamer protocol checks
// Request and stream hold rules plus idle outputs out of reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps

module strm_chk
  import strm_pkg::*;
(
  input logic          clk_i,
  input logic          rst_n_i,
  input logic          clear_i,
  input strm_mem_req_t ch_req_i [4],
  input logic [3:0]    ch_gnt_i,
  input strm_mem_req_t mem_req_i,
  input strm_flags_t   flags_i,
  input logic          z_ready_i,
  input logic          valid_i [3],
  input strm_beat_t    beat_i [3],
  input logic          ready_i [3]
);

  // Sticky, set by any failing assertion
  logic failed = 1'b0;

  // Pending channel request keeps direction, address and data until granted
  for (genvar i = 0; i < 4; i++) begin : gen_req
    req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      ch_req_i[i].req && !ch_gnt_i[i] |=> ch_req_i[i].req && $stable(ch_req_i[i]))
    else begin
      $error("channel %0d request changed before its grant", i);
      failed = 1'b1;
    end
  end

  // Load stream beat held while the consumer stalls
  for (genvar i = 0; i < 3; i++) begin : gen_strm
    beat_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
      valid_i[i] && !ready_i[i] |=> valid_i[i] && $stable(beat_i[i]))
    else begin
      $error("load stream %0d dropped or changed a beat before ready", i);
      failed = 1'b1;
    end
  end

  // First edge out of reset
  idle_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !mem_req_i.req && !valid_i[0] && !valid_i[1] && !valid_i[2]
                       && !z_ready_i && flags_i == '0)
  else begin
    $error("streamer not idle after reset");
    failed = 1'b1;
  end

endmodule : strm_chk

// ==== tb/strm_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory streamer testbench
// Job table run against the streamer with a memory model and stream ends
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`include "strm_settings.svh"

module strm_tb
  import strm_pkg::*;
();

  localparam int          CLK_HALF        = 50;
  localparam int          DRIVE_DLY       = 1;
  localparam int          MEM_WORDS       = 1024;
  localparam int          CYCLES_PER_BEAT = 30;
  localparam int          LIMIT_SLACK     = 200;
  localparam logic [31:0] LFSR_SEED       = 32'h492a1154;

  // One table row with jobs, start mask and run options
  typedef struct packed {
    strm_cfg_t cfg;
    logic      bp;
    logic      clr;
  } row_t;

  logic                clk;
  logic                rst_n;
  logic                clear;
  strm_cfg_t           cfg;
  strm_flags_t         flags;
  strm_beat_t          x_beat;
  logic                x_valid;
  strm_beat_t          w_beat;
  logic                w_valid;
  strm_beat_t          y_beat;
  logic                y_valid;
  logic [2:0]          rdy;
  strm_beat_t          z_beat;
  logic                z_valid;
  logic                z_ready;
  strm_mem_req_t       mem_req;
  logic                mem_gnt;
  strm_mem_rsp_t       mem_rsp;

  // Memory model and its untouched copy for expected load data
  logic [`STRM_DW-1:0] mem     [MEM_WORDS];
  logic [`STRM_DW-1:0] ref_mem [MEM_WORDS];
  logic [`STRM_DW-1:0] z_data  [256];
  logic [31:0]         lfsr_q;
  row_t                rows [$];
  string               names [$];
  strm_job_t           job [4];
  int                  beat_cnt [3];
  int                  z_idx;
  bit                  z_on;
  bit                  bp_en;
  bit                  quiet;
  logic [3:0]          done_exp;
  strm_flags_t         flags_s;
  strm_mem_rsp_t       rsp_next;
  string               test_name;
  int                  cycle_cnt;
  int                  cycle_limit;

  strm_top u_strm_top (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .clear_i   (clear),
    .cfg_i     (cfg),
    .flags_o   (flags),
    .x_beat_o  (x_beat),
    .x_valid_o (x_valid),
    .x_ready_i (rdy[STRM_CH_X]),
    .w_beat_o  (w_beat),
    .w_valid_o (w_valid),
    .w_ready_i (rdy[STRM_CH_W]),
    .y_beat_o  (y_beat),
    .y_valid_o (y_valid),
    .y_ready_i (rdy[STRM_CH_Y]),
    .z_beat_i  (z_beat),
    .z_valid_i (z_valid),
    .z_ready_o (z_ready),
    .mem_req_o (mem_req),
    .mem_gnt_i (mem_gnt),
    .mem_rsp_i (mem_rsp)
  );

  // Protocol checks on channel requests and load streams
  bind strm_top strm_chk u_strm_chk (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .clear_i   (clear_i),
    .ch_req_i  (ch_req),
    .ch_gnt_i  (ch_gnt),
    .mem_req_i (mem_req_o),
    .flags_i   (flags_o),
    .z_ready_i (z_ready_o),
    .valid_i   (src_valid),
    .beat_i    (src_beat),
    .ready_i   (src_ready)
  );

  always #CLK_HALF clk = ~clk;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < 32; b++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // Word of beat i at base + i * stride
  function automatic int word_index(strm_job_t j, int i);
    return (int'(j.base) + i * int'(j.stride)) % MEM_WORDS;
  endfunction

  function automatic strm_job_t make_job(int base, int stride, int length);
    strm_job_t j;
    j.base   = base[`STRM_AW-1:0];
    j.stride = stride[`STRM_LW-1:0];
    j.length = length[`STRM_LW-1:0];
    return j;
  endfunction

  // Beats moved by the started channels of a row
  function automatic int row_beats(row_t r);
    int n;
    n = 0;
    if (r.cfg.start[STRM_CH_X]) n += int'(r.cfg.x.length);
    if (r.cfg.start[STRM_CH_W]) n += int'(r.cfg.w.length);
    if (r.cfg.start[STRM_CH_Y]) n += int'(r.cfg.y.length);
    if (r.cfg.start[STRM_CH_Z]) n += int'(r.cfg.z.length);
    return n;
  endfunction

  task automatic stop_run();
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_problem(string msg);
    $display("%s", msg);
    stop_run();
  endtask

  task automatic check_beat(string what, strm_beat_t exp_beat, strm_beat_t act);
    if (act !== exp_beat) begin
      $display("CHECK FAILED %s: expected data %08h last %0b, actual data %08h last %0b",
               what, exp_beat.data, exp_beat.last, act.data, act.last);
      stop_run();
    end
  endtask

  task automatic check_word(string what, logic [`STRM_DW-1:0] exp_word,
                            logic [`STRM_DW-1:0] act);
    if (act !== exp_word) begin
      $display("CHECK FAILED %s: expected %08h, actual %08h", what, exp_word, act);
      stop_run();
    end
  endtask

  task automatic check_flags(string what, strm_flags_t exp_flags, strm_flags_t act);
    if (act !== exp_flags) begin
      $display("CHECK FAILED %s: expected done %04b busy %04b, actual done %04b busy %04b",
               what, exp_flags.done, exp_flags.busy, act.done, act.busy);
      stop_run();
    end
  endtask

  task automatic add_row(string name, strm_job_t x, strm_job_t w, strm_job_t y,
                         strm_job_t z, logic [3:0] start, logic bp, logic clr);
    row_t r;
    r.cfg.x     = x;
    r.cfg.w     = w;
    r.cfg.y     = y;
    r.cfg.z     = z;
    r.cfg.start = start;
    r.bp        = bp;
    r.clr       = clr;
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    strm_job_t none;
    none = '0;
    add_row("single_x", make_job(16, 1, 8), none, none, none, 4'b0001, 1'b0, 1'b0);
    add_row("xwy_concurrent", make_job(100, 2, 6), make_job(300, 3, 5), make_job(500, 1, 7),
            none, 4'b0111, 1'b0, 1'b0);
    add_row("z_store_with_x", make_job(40, 1, 4), none, none, make_job(700, 3, 6),
            4'b1001, 1'b0, 1'b0);
    add_row("xwy_random", make_job(100, 2, 6), make_job(300, 3, 5), make_job(500, 1, 7),
            none, 4'b0111, 1'b1, 1'b0);
    // Cut short by clear, then a fresh X job
    add_row("clear_mid_job", make_job(200, 1, 8), none, make_job(260, 2, 8), none,
            4'b0101, 1'b1, 1'b1);
    add_row("after_clear", make_job(64, 5, 6), none, none, none, 4'b0001, 1'b0, 1'b0);
  endtask

  // Expected beat from the untouched memory copy
  task automatic consume_beat(int c, strm_beat_t act);
    strm_beat_t exp_beat;
    int         n;
    n = beat_cnt[c];
    if (n >= int'(job[c].length)) begin
      report_problem($sformatf("%s: load channel %0d sent a beat beyond its job",
                               test_name, c));
    end else begin
      exp_beat.data = ref_mem[word_index(job[c], n)];
      exp_beat.last = (n == int'(job[c].length) - 1);
      check_beat($sformatf("%s ch%0d beat %0d", test_name, c, n), exp_beat, act);
      beat_cnt[c] = n + 1;
    end
  endtask

  // Sample at the falling edge, drive just after the rising edge
  task automatic step_cycle();
    strm_beat_t  beats [3];
    logic [2:0]  vld;
    strm_flags_t idle_flags;
    @(negedge clk);
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      report_problem($sformatf("Timeout: jobs not finished within %0d cycles", cycle_limit));
    end
    if (u_strm_top.u_strm_chk.failed) begin
      report_problem("A protocol assertion on a memory request or stream fired");
    end
    beats[STRM_CH_X] = x_beat;
    beats[STRM_CH_W] = w_beat;
    beats[STRM_CH_Y] = y_beat;
    vld              = {y_valid, w_valid, x_valid};
    flags_s          = flags;
    // Idle window after reset or clear
    if (quiet) begin
      idle_flags = '0;
      check_flags({test_name, " idle"}, idle_flags, flags_s);
      if (mem_req.req || vld != 3'b000 || z_ready) begin
        report_problem($sformatf("%s: request, valid or Z ready seen while idle", test_name));
      end
    end
    for (int c = 0; c < 3; c++) begin
      if (vld[c] && rdy[c]) begin
        consume_beat(c, beats[c]);
      end
    end
    if (z_valid && z_ready) begin
      z_idx++;
    end
    // Grant at the coming edge, read data one cycle later
    rsp_next = '0;
    if (mem_req.req && mem_gnt) begin
      if (mem_req.we) begin
        mem[mem_req.addr[9:0]] = mem_req.wdata;
      end else begin
        rsp_next.rvalid = 1'b1;
        rsp_next.rdata  = mem[mem_req.addr[9:0]];
      end
    end
    @(posedge clk);
    #DRIVE_DLY;
    mem_rsp = rsp_next;
    mem_gnt = bp_en ? lfsr_bit() : 1'b1;
    for (int c = 0; c < 3; c++) begin
      rdy[c] = bp_en ? lfsr_bit() : 1'b1;
    end
    // Z beat held until taken
    if (z_on && z_idx < int'(job[STRM_CH_Z].length)) begin
      z_valid     = 1'b1;
      z_beat.data = z_data[z_idx];
      z_beat.last = (z_idx == int'(job[STRM_CH_Z].length) - 1);
    end else begin
      z_valid = 1'b0;
      z_beat  = '0;
    end
  endtask

  task automatic run_row(int r);
    row_t        row;
    logic [3:0]  mask;
    strm_flags_t exp_flags;
    row       = rows[r];
    test_name = names[r];
    mask      = row.cfg.start;
    // Unstarted channels get an empty job, so any beat there fails
    job[STRM_CH_X] = mask[STRM_CH_X] ? row.cfg.x : '0;
    job[STRM_CH_W] = mask[STRM_CH_W] ? row.cfg.w : '0;
    job[STRM_CH_Y] = mask[STRM_CH_Y] ? row.cfg.y : '0;
    job[STRM_CH_Z] = mask[STRM_CH_Z] ? row.cfg.z : '0;
    for (int c = 0; c < 3; c++) begin
      beat_cnt[c] = 0;
    end
    for (int i = 0; i < int'(job[STRM_CH_Z].length); i++) begin
      z_data[i] = lfsr_word();
    end
    z_idx = 0;
    z_on  = mask[STRM_CH_Z];
    bp_en = row.bp;
    // One cycle start pulse
    cfg = row.cfg;
    step_cycle();
    cfg.start = '0;
    // Started channels turn busy and drop done one cycle after the pulse
    step_cycle();
    exp_flags.done = done_exp & ~mask;
    exp_flags.busy = mask;
    check_flags({test_name, " start"}, exp_flags, flags_s);
    if (row.clr) begin
      repeat (5) step_cycle();
      clear = 1'b1;
      step_cycle();
      clear    = 1'b0;
      z_on     = 1'b0;
      done_exp = '0;
      quiet    = 1'b1;
      repeat (8) step_cycle();
      quiet = 1'b0;
    end else begin
      do begin
        step_cycle();
      end while ((flags_s.done & mask) != mask);
      done_exp       = done_exp | mask;
      exp_flags.done = done_exp;
      exp_flags.busy = 4'b0000;
      check_flags({test_name, " flags"}, exp_flags, flags_s);
      for (int c = 0; c < 3; c++) begin
        if (beat_cnt[c] != int'(job[c].length)) begin
          report_problem($sformatf("%s: channel %0d done after %0d of %0d beats", test_name,
                                   c, beat_cnt[c], job[c].length));
        end
      end
      if (z_idx != int'(job[STRM_CH_Z].length)) begin
        report_problem($sformatf("%s: Z done after %0d of %0d beats", test_name, z_idx,
                                 job[STRM_CH_Z].length));
      end
      // Stored words at their strided addresses
      for (int i = 0; i < int'(job[STRM_CH_Z].length); i++) begin
        check_word($sformatf("%s z word %0d", test_name, i), z_data[i],
                   mem[word_index(job[STRM_CH_Z], i)]);
      end
    end
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    clear     = 1'b0;
    cfg       = '0;
    rdy       = '0;
    z_beat    = '0;
    z_valid   = 1'b0;
    mem_gnt   = 1'b0;
    mem_rsp   = '0;
    z_on      = 1'b0;
    bp_en     = 1'b0;
    quiet     = 1'b0;
    done_exp  = '0;
    z_idx     = 0;
    cycle_cnt = 0;
    lfsr_q    = LFSR_SEED;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a]     = lfsr_word();
      ref_mem[a] = mem[a];
    end
    build_table();
    cycle_limit = LIMIT_SLACK;
    foreach (rows[r]) begin
      cycle_limit += CYCLES_PER_BEAT * row_beats(rows[r]);
    end
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    // Flags zero, no request and no valid out of reset
    test_name = "reset_idle";
    quiet     = 1'b1;
    repeat (3) step_cycle();
    quiet = 1'b0;
    foreach (rows[r]) begin
      run_row(r);
    end
    if (u_strm_top.u_strm_chk.failed) begin
      report_problem("A protocol assertion on a memory request or stream fired");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule : strm_tb

// ==== tb.f ====
+incdir+rtl
rtl/strm_pkg.sv
rtl/strm_addr_gen.sv
rtl/strm_fifo.sv
rtl/strm_source.sv
rtl/strm_sink.sv
rtl/strm_mem_arb.sv
rtl/strm_top.sv
tb/strm_chk.sv
tb/strm_tb.sv
